// File: tag_params.svh
// tag network sizing
// client count, value width and client index width

`ifndef TAG_PARAMS_SVH
`define TAG_PARAMS_SVH

// number of tag clients on the bus
`define TAG_NUM_CLIENTS 4

// bits in one configuration value
`define TAG_DATA_WIDTH 8

// bits needed to name one client
`define TAG_ID_WIDTH 2

`endif

// File: tag_pkg.sv
// tag network types
// shared vectors, structs and the master FSM states

`default_nettype none

`include "tag_params.svh"

package tag_pkg;

   // one configuration value
   typedef logic [`TAG_DATA_WIDTH-1:0] tag_data_t;

   // index of one client
   typedef logic [`TAG_ID_WIDTH-1:0] tag_id_t;

   // host command, reset set means clear the client instead of writing
   typedef struct packed {
      tag_id_t   id;
      logic      reset;
      tag_data_t data;
   } tag_cmd_s;

   // serial line pair of one client
   typedef struct packed {
      logic op;
      logic param;
   } tag_lines_s;

   // update report from the collector
   typedef struct packed {
      tag_id_t   id;
      tag_data_t data;
   } tag_upd_s;

   // all client values side by side
   typedef tag_data_t [`TAG_NUM_CLIENTS-1:0] tag_cfg_t;

   // master FSM
   typedef enum logic [1:0] {
      st_idle,
      st_reset,
      st_shift,
      st_send
   } tag_master_state_e;

endpackage

`default_nettype wire

// File: tag_master.sv
// tag master
// serializes host write and reset commands onto one client's op/param lines

`timescale 1ns/100ps
`default_nettype none

`include "tag_params.svh"

module tag_master
   (
   input  wire logic                                        bsg_tag_i,
   input  wire logic                                        rst_n_i,
   input  wire logic                                        cmd_v_i,
   input  wire tag_pkg::tag_cmd_s                           cmd_i,
   output logic                                             busy_o,
   output tag_pkg::tag_lines_s [`TAG_NUM_CLIENTS-1:0]       lines_o
   );

   import tag_pkg::*;

   // wide enough for the shift count and the trailing no-op count
   localparam int cnt_width_lp = $clog2(`TAG_DATA_WIDTH + 1);

   tag_master_state_e         state_r;
   logic [cnt_width_lp-1:0]   cnt_r;
   logic                      accept;
   tag_id_t                   id_r;
   tag_data_t                 data_r;
   logic [`TAG_NUM_CLIENTS-1:0] line_act;

   // busy whenever the FSM has left idle
   assign busy_o = (state_r != st_idle);

   // commands only count while idle, anything else is dropped
   assign accept = cmd_v_i & ~busy_o;

   always_ff @(posedge bsg_tag_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_r <= st_idle;
         cnt_r   <= '0;
      end
      else
      begin
         case (state_r)
            st_idle:
            begin
               if (accept)
               begin
                  if (cmd_i.reset)
                  begin
                     state_r <= st_reset;
                  end
                  else
                  begin
                     // W shift cycles, counted down to zero
                     state_r <= st_shift;
                     cnt_r   <= cnt_width_lp'(`TAG_DATA_WIDTH - 1);
                  end
               end
            end
            st_reset:
            begin
               // reset op is followed by a single no-op
               state_r <= st_send;
               cnt_r   <= '0;
            end
            st_shift:
            begin
               if (cnt_r == '0)
               begin
                  // two no-ops close a write
                  state_r <= st_send;
                  cnt_r   <= cnt_width_lp'(1);
               end
               else
               begin
                  cnt_r <= cnt_r - 1'b1;
               end
            end
            st_send:
            begin
               if (cnt_r == '0)
               begin
                  state_r <= st_idle;
               end
               else
               begin
                  cnt_r <= cnt_r - 1'b1;
               end
            end
            default:
            begin
               state_r <= st_idle;
            end
         endcase
      end
   end

   // latched target and data word, lsb leaves first
   always_ff @(posedge bsg_tag_i)
   begin
      if (accept)
      begin
         id_r   <= cmd_i.id;
         data_r <= cmd_i.data;
      end
      else if (state_r == st_shift)
      begin
         data_r <= data_r >> 1;
      end
   end

   // only the addressed client sees anything but a no-op
   always_comb
   begin
      lines_o = '0;
      case (state_r)
         st_shift:
         begin
            lines_o[id_r].op    = 1'b1;
            lines_o[id_r].param = data_r[0];
         end
         st_reset:
         begin
            lines_o[id_r].param = 1'b1;
         end
         default:
         begin
         end
      endcase
   end

   always_comb
   begin
      for (int i = 0; i < `TAG_NUM_CLIENTS; i++)
      begin
         line_act[i] = lines_o[i].op | lines_o[i].param;
      end
   end

   // the bus never talks to two clients at once
   a_one_client: assert property (@(posedge bsg_tag_i) disable iff (!rst_n_i)
      $onehot0(line_act));

endmodule

`default_nettype wire

// File: tag_client.sv
// tag client
// shifts in a value on the tag clock and hands it to the receive clock domain

`timescale 1ns/100ps
`default_nettype none

`include "tag_params.svh"

module tag_client
   (
   input  wire logic                bsg_tag_i,
   input  wire logic                rst_n_i,
   input  wire logic                recv_clk_i,
   input  wire logic                en_i,
   input  wire tag_pkg::tag_lines_s lines_i,
   output logic                     recv_new_o,
   output tag_pkg::tag_data_t       recv_data_o
   );

   import tag_pkg::*;

   logic      op_r;
   logic      param_r;
   logic      op_r_r;
   logic      reset_op;
   logic      shift_op;
   logic      no_op;
   logic      send_now;
   tag_data_t tag_data_r;
   logic      tag_toggle_r;

   logic      recv_sync1_r;
   logic      recv_sync2_r;
   logic      recv_toggle_r;
   logic      recv_new;
   logic      recv_new_r;
   logic      recv_new_r_r;
   tag_data_t recv_data_r;

   // tag side

   // line registers, op is kept one extra cycle for the send decision
   always_ff @(posedge bsg_tag_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         op_r    <= 1'b0;
         param_r <= 1'b0;
         op_r_r  <= 1'b0;
      end
      else
      begin
         op_r    <= lines_i.op;
         param_r <= lines_i.param;
         op_r_r  <= op_r;
      end
   end

   assign reset_op = ~op_r & param_r;
   assign shift_op = op_r;
   assign no_op    = ~op_r & ~param_r;

   // end of a shift burst, or a reset, launches the value
   assign send_now = (op_r_r & no_op) | reset_op;

   // param enters at the msb, so lsb-first data lands in order
   always_ff @(posedge bsg_tag_i)
   begin
      if (reset_op)
      begin
         tag_data_r <= '0;
      end
      else if (shift_op)
      begin
         tag_data_r <= tag_data_t'({param_r, tag_data_r} >> 1);
      end
   end

   // each send flips the toggle once
   always_ff @(posedge bsg_tag_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         tag_toggle_r <= 1'b0;
      end
      else
      begin
         tag_toggle_r <= tag_toggle_r ^ send_now;
      end
   end

   // receive side

   // two-flop synchronizer plus a flop for edge detection
   always_ff @(posedge recv_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         recv_sync1_r  <= 1'b0;
         recv_sync2_r  <= 1'b0;
         recv_toggle_r <= 1'b0;
         recv_new_r    <= 1'b0;
         recv_new_r_r  <= 1'b0;
      end
      else
      begin
         recv_sync1_r  <= tag_toggle_r;
         recv_sync2_r  <= recv_sync1_r;
         recv_toggle_r <= recv_sync2_r;
         recv_new_r    <= recv_new;
         recv_new_r_r  <= recv_new_r;
      end
   end

   // en_i must only move while the bus is quiet
   assign recv_new = (recv_sync2_r ^ recv_toggle_r) & en_i;

   // tag data has been stable since before the toggle left
   always_ff @(posedge recv_clk_i)
   begin
      if (recv_new)
      begin
         recv_data_r <= tag_data_r;
      end
   end

   // pulse trails the load so the value is settled when it shows
   assign recv_new_o  = recv_new_r_r & en_i;
   assign recv_data_o = recv_data_r;

   a_new_single: assert property (@(posedge recv_clk_i) disable iff (!rst_n_i)
      recv_new_o |=> !recv_new_o);

endmodule

`default_nettype wire

// File: tag_collector.sv
// tag collector
// keeps every client's value in the receive domain and reports each update

`timescale 1ns/100ps
`default_nettype none

`include "tag_params.svh"

module tag_collector
   (
   input  wire logic                        recv_clk_i,
   input  wire logic                        rst_n_i,
   input  wire logic [`TAG_NUM_CLIENTS-1:0] new_i,
   input  wire tag_pkg::tag_cfg_t           data_i,
   output logic                             upd_v_o,
   output tag_pkg::tag_upd_s                upd_o,
   output tag_pkg::tag_cfg_t                cfg_o
   );

   import tag_pkg::*;

   tag_id_t new_id;
   logic    any_new;

   // one-hot to index, at most one client fires per cycle
   always_comb
   begin
      new_id = '0;
      for (int i = 0; i < `TAG_NUM_CLIENTS; i++)
      begin
         if (new_i[i])
         begin
            new_id = tag_id_t'(i);
         end
      end
   end

   assign any_new = |new_i;

   // strobe and value table move together
   always_ff @(posedge recv_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         upd_v_o <= 1'b0;
         cfg_o   <= '0;
      end
      else
      begin
         upd_v_o <= any_new;
         if (any_new)
         begin
            cfg_o[new_id] <= data_i[new_id];
         end
      end
   end

   // report payload, only meaningful with upd_v_o
   always_ff @(posedge recv_clk_i)
   begin
      if (any_new)
      begin
         upd_o.id   <= new_id;
         upd_o.data <= data_i[new_id];
      end
   end

   a_new_onehot: assert property (@(posedge recv_clk_i) disable iff (!rst_n_i)
      $onehot0(new_i));

endmodule

`default_nettype wire

// File: tag_subsystem_top.sv
// tag subsystem top
// master driving a bank of clients, drained by one receive-side collector

`timescale 1ns/100ps
`default_nettype none

`include "tag_params.svh"

module tag_subsystem_top
   (
   input  wire logic              bsg_tag_i,
   input  wire logic              recv_clk_i,
   input  wire logic              rst_n_i,
   input  wire logic              en_i,
   input  wire logic              cmd_v_i,
   input  wire tag_pkg::tag_cmd_s cmd_i,
   output logic                   busy_o,
   output logic                   upd_v_o,
   output tag_pkg::tag_upd_s      upd_o,
   output tag_pkg::tag_cfg_t      cfg_o
   );

   import tag_pkg::*;

   tag_lines_s [`TAG_NUM_CLIENTS-1:0] lines;
   logic [`TAG_NUM_CLIENTS-1:0]       recv_new;
   tag_cfg_t                          recv_data;

   tag_master u_master
      (
      .bsg_tag_i (bsg_tag_i),
      .rst_n_i   (rst_n_i),
      .cmd_v_i   (cmd_v_i),
      .cmd_i     (cmd_i),
      .busy_o    (busy_o),
      .lines_o   (lines)
      );

   // one client per configuration slot
   for (genvar i = 0; i < `TAG_NUM_CLIENTS; i++)
   begin : g_client
      tag_client u_client
         (
         .bsg_tag_i   (bsg_tag_i),
         .rst_n_i     (rst_n_i),
         .recv_clk_i  (recv_clk_i),
         .en_i        (en_i),
         .lines_i     (lines[i]),
         .recv_new_o  (recv_new[i]),
         .recv_data_o (recv_data[i])
         );
   end

   tag_collector u_collector
      (
      .recv_clk_i (recv_clk_i),
      .rst_n_i    (rst_n_i),
      .new_i      (recv_new),
      .data_i     (recv_data),
      .upd_v_o    (upd_v_o),
      .upd_o      (upd_o),
      .cfg_o      (cfg_o)
      );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// testbench clock and reset source
// tag clock, receive clock and an active-low reset held for a few tag cycles

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
   #(
   parameter int tag_half_p     = 10,
   parameter int recv_half_p    = 7,
   parameter int reset_cycles_p = 4
   )
   (
   output logic bsg_tag_o,
   output logic recv_clk_o,
   output logic rst_n_o
   );

   // both clocks start low, the receive clock runs faster and drifts in phase
   initial
   begin
      bsg_tag_o  = 1'b0;
      recv_clk_o = 1'b0;
   end

   always #(tag_half_p) bsg_tag_o = ~bsg_tag_o;

   always #(recv_half_p) recv_clk_o = ~recv_clk_o;

   // release on a falling tag edge, away from any tag sampling edge
   initial
   begin
      rst_n_o = 1'b0;
      repeat (reset_cycles_p) @(posedge bsg_tag_o);
      @(negedge bsg_tag_o);
      rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// File: tb_tag_subsystem.sv
// tag subsystem testbench
// directed writes and resets through the master, checked against a value model

`timescale 1ns/100ps
`default_nettype none

`include "tag_params.svh"

module tb_tag_subsystem;

   import tag_pkg::*;

   localparam int tag_period_lp = 20;
   // tag cycles allowed for busy_o to drop and for an update to show up
   localparam int busy_wait_lp  = `TAG_DATA_WIDTH + 8;
   localparam int upd_wait_lp   = 40;
   localparam int num_rand_lp   = 12;
   // every command issued over all tests, plus two quiet windows
   localparam int num_cmds_lp   = 4 + num_rand_lp + 2 + 2 + 2;
   localparam int cmd_cycles_lp = 2 * busy_wait_lp + upd_wait_lp + 4;
   localparam int watchdog_lp   = num_cmds_lp * cmd_cycles_lp + 2 * upd_wait_lp + 50;

   logic       bsg_tag_i;
   logic       recv_clk_i;
   logic       rst_n_i;
   logic       en_i;
   logic       cmd_v_i;
   tag_cmd_s   cmd_i;
   logic       busy_o;
   logic       upd_v_o;
   tag_upd_s   upd_o;
   tag_cfg_t   cfg_o;

   tag_cfg_t   model_cfg;
   tag_upd_s   upd_q[$];
   logic [31:0] lfsr_r;
   int         mismatch_cnt;
   int         fail_cnt;

   tb_clock_gen #(.tag_half_p(tag_period_lp / 2), .recv_half_p(7), .reset_cycles_p(4)) u_clk
      (
      .bsg_tag_o  (bsg_tag_i),
      .recv_clk_o (recv_clk_i),
      .rst_n_o    (rst_n_i)
      );

   tag_subsystem_top DUT
      (
      .bsg_tag_i  (bsg_tag_i),
      .recv_clk_i (recv_clk_i),
      .rst_n_i    (rst_n_i),
      .en_i       (en_i),
      .cmd_v_i    (cmd_v_i),
      .cmd_i      (cmd_i),
      .busy_o     (busy_o),
      .upd_v_o    (upd_v_o),
      .upd_o      (upd_o),
      .cfg_o      (cfg_o)
      );

   // collect every update report, sampled mid-cycle in the receive domain
   always @(negedge recv_clk_i)
   begin
      if (rst_n_i && upd_v_o)
      begin
         upd_q.push_back(upd_o);
      end
   end

   initial
   begin
      #(watchdog_lp * tag_period_lp);
      $display("watchdog expired after %0d tag cycles, the run did not finish", watchdog_lp);
      $display("Test failed");
      $finish;
   end

   // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] draw_bits(input int n);
      logic        fb;
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         fb     = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
         lfsr_r = {lfsr_r[30:0], fb};
         val    = {val[30:0], fb};
      end
      return val;
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_upd(input tag_upd_s got, input tag_upd_s exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("mismatch upd_o: got %h expected %h", got, exp);
      end
   endtask

   task automatic check_cfg(input tag_cfg_t got, input tag_cfg_t exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("mismatch cfg_o: got %h expected %h", got, exp);
      end
   endtask

   // sampled on falling tag edges, where busy_o is settled
   task automatic wait_idle();
      int n;
      n = 0;
      while (busy_o && n < busy_wait_lp)
      begin
         @(negedge bsg_tag_i);
         n++;
      end
      if (busy_o)
      begin
         fail_cnt++;
         $display("busy_o stayed high for %0d tag cycles", busy_wait_lp);
      end
   endtask

   // one-cycle strobe, accepted on the rising edge in between
   task automatic issue_cmd(input tag_cmd_s cmd);
      @(negedge bsg_tag_i);
      cmd_v_i = 1'b1;
      cmd_i   = cmd;
      @(negedge bsg_tag_i);
      cmd_v_i = 1'b0;
   endtask

   task automatic send_write(input tag_id_t id, input tag_data_t data);
      wait_idle();
      issue_cmd('{id: id, reset: 1'b0, data: data});
      wait_idle();
   endtask

   task automatic expect_update(input tag_upd_s exp);
      int n;
      n = 0;
      while (upd_q.size() == 0 && n < upd_wait_lp)
      begin
         @(negedge bsg_tag_i);
         n++;
      end
      if (upd_q.size() == 0)
      begin
         fail_cnt++;
         $display("no update arrived for client %0d within %0d cycles", exp.id, upd_wait_lp);
      end
      else
      begin
         check_upd(upd_q.pop_front(), exp);
      end
      check_cfg(cfg_o, model_cfg);
   endtask

   task automatic expect_no_update();
      repeat (upd_wait_lp) @(negedge bsg_tag_i);
      if (upd_q.size() != 0)
      begin
         fail_cnt++;
         $display("%0d unexpected update reports arrived", upd_q.size());
         upd_q.delete();
      end
   endtask

   task automatic write_client(input tag_id_t id, input tag_data_t data);
      send_write(id, data);
      model_cfg[id] = data;
      expect_update('{id: id, data: data});
   endtask

   task automatic reset_client(input tag_id_t id);
      wait_idle();
      issue_cmd('{id: id, reset: 1'b1, data: '0});
      wait_idle();
      model_cfg[id] = '0;
      expect_update('{id: id, data: '0});
   endtask

   task automatic after_reset_values();
      check_bit("busy_o", busy_o, 1'b0);
      check_bit("upd_v_o", upd_v_o, 1'b0);
      check_cfg(cfg_o, '0);
   endtask

   task automatic known_patterns();
      for (int i = 0; i < `TAG_NUM_CLIENTS; i++)
      begin
         write_client(tag_id_t'(i), tag_data_t'(8'ha5 ^ (i * 8'h11)));
      end
   endtask

   task automatic random_writes();
      logic [31:0] id_bits;
      logic [31:0] data_bits;
      for (int i = 0; i < num_rand_lp; i++)
      begin
         id_bits   = draw_bits(`TAG_ID_WIDTH);
         data_bits = draw_bits(`TAG_DATA_WIDTH);
         write_client(tag_id_t'(id_bits % `TAG_NUM_CLIENTS), tag_data_t'(data_bits));
      end
   endtask

   // a known non-zero value first so the clear is visible
   task automatic client_clear();
      write_client(tag_id_t'(2 % `TAG_NUM_CLIENTS), tag_data_t'(8'hc3));
      reset_client(tag_id_t'(2 % `TAG_NUM_CLIENTS));
   endtask

   // en_i only moves while the master is idle
   task automatic enable_gating();
      wait_idle();
      en_i = 1'b0;
      send_write(tag_id_t'(1), ~model_cfg[1]);
      expect_no_update();
      check_cfg(cfg_o, model_cfg);
      @(negedge bsg_tag_i);
      en_i = 1'b1;
      write_client(tag_id_t'(1), tag_data_t'(8'h3c));
   endtask

   // second strobe lands one cycle into the first command
   task automatic busy_command_drop();
      tag_cmd_s first;
      tag_cmd_s second;
      first  = '{id: tag_id_t'(0), reset: 1'b0, data: tag_data_t'(8'h5a)};
      second = '{id: tag_id_t'(3 % `TAG_NUM_CLIENTS), reset: 1'b0, data: tag_data_t'(8'h96)};
      wait_idle();
      @(negedge bsg_tag_i);
      cmd_v_i = 1'b1;
      cmd_i   = first;
      @(negedge bsg_tag_i);
      cmd_i   = second;
      @(negedge bsg_tag_i);
      cmd_v_i = 1'b0;
      wait_idle();
      model_cfg[first.id] = first.data;
      expect_update('{id: first.id, data: first.data});
      expect_no_update();
      check_cfg(cfg_o, model_cfg);
   endtask

   initial
   begin
      en_i         = 1'b1;
      cmd_v_i      = 1'b0;
      cmd_i        = '0;
      model_cfg    = '0;
      lfsr_r       = 32'hf05b0ac0;
      mismatch_cnt = 0;
      fail_cnt     = 0;
      @(posedge rst_n_i);
      @(negedge bsg_tag_i);
      after_reset_values();
      known_patterns();
      random_writes();
      client_clear();
      enable_gating();
      busy_command_drop();
      $display("summary: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0)
      begin
         $display("Test completed successfully");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tag_subsystem.f
+incdir+.
tag_pkg.sv
tag_master.sv
tag_client.sv
tag_collector.sv
tag_subsystem_top.sv
tb_clock_gen.sv
tb_tag_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert -Wno-fatal
TOP       ?= tb_tag_subsystem
RTL_TOP   ?= tag_subsystem_top
FLIST     ?= tag_subsystem.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST) | grep -v '^+') tag_params.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
